//--- include/tlb_l2_defines.svh
// L2 TLB sizes, address widths and tag word layout
`ifndef TLB_L2_DEFINES_SVH
`define TLB_L2_DEFINES_SVH

// Address widths
`define TLB_VA_WIDTH        32
`define TLB_PA_WIDTH        40
`define TLB_PAGE_BITS       12   // 4 kB pages
`define TLB_VPN_WIDTH       20
`define TLB_PPN_WIDTH       28

// Organisation
`define TLB_NUM_BANKS       4
`define TLB_BANK_BITS       2
`define TLB_NUM_SETS        8
`define TLB_SET_BITS        3
`define TLB_WAYS_PER_BANK   4
`define TLB_WAY_BITS        2

// Config port, address is {region, set, way, bank}
`define TLB_CFG_ADDR_WIDTH  8
`define TLB_CFG_DATA_WIDTH  32
`define TLB_TAG_VALID_BIT   20
`define TLB_TAG_RO_BIT      21

`endif

//--- rtl/tlb_l2_pkg.sv
// L2 TLB shared types for FSM states, response kinds and index fields
`default_nettype none

`include "tlb_l2_defines.svh"

package tlb_l2_pkg;

   // Search controller FSM
   typedef enum logic [1:0] {IDLE, SEARCH, DONE} search_state_e;

   // PA lookup and response FSM
   typedef enum logic [1:0] {RESP_IDLE, WAIT_ON_WRITE, READ_PA, RESP_SEND} resp_state_e;

   // Lookup result
   typedef enum logic [1:0] {RESP_HIT, RESP_MISS, RESP_PROT} resp_kind_e;

   typedef logic [`TLB_VPN_WIDTH-1:0] vpn_t;
   typedef logic [`TLB_PPN_WIDTH-1:0] ppn_t;
   typedef logic [`TLB_SET_BITS-1:0]  set_idx_t;
   typedef logic [`TLB_WAY_BITS-1:0]  way_idx_t;

   // PA RAM index, {set, way, bank} like the lower config address bits
   typedef logic [`TLB_SET_BITS+`TLB_WAY_BITS+`TLB_BANK_BITS-1:0] entry_idx_t;

endpackage

`default_nettype wire

//--- rtl/tlb_va_bank.sv
// L2 TLB tag bank with per-entry valid and read-only flags and a registered tag compare
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_defines.svh"

module tlb_va_bank (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           bank_we_i,
   input  tlb_l2_pkg::set_idx_t           set_i,
   input  tlb_l2_pkg::way_idx_t           way_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] wdata_i,
   input  logic                           rd_en_i,
   input  tlb_l2_pkg::vpn_t               req_vpn_i,
   input  logic                           req_write_i,
   output logic                           hit_o,
   output logic                           prot_o
);

   localparam int DEPTH = `TLB_NUM_SETS * `TLB_WAYS_PER_BANK;

   tlb_l2_pkg::vpn_t                         vpn_mem [DEPTH];
   logic [DEPTH-1:0]                         ro_mem;
   logic [DEPTH-1:0]                         valid_q;
   logic [`TLB_SET_BITS+`TLB_WAY_BITS-1:0]   idx;

   tlb_l2_pkg::vpn_t                         rd_vpn_q;
   logic                                     rd_ro_q;
   logic                                     rd_valid_q;

   assign idx = {set_i, way_i};   // Same port for write and read

   ////////////////////////////////////////////////////////////////////////////
   // Tag storage

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         valid_q <= '0;
      end else if (bank_we_i) begin
         valid_q[idx] <= wdata_i[`TLB_TAG_VALID_BIT];
      end
   end

   always_ff @(posedge clk_i) begin
      if (bank_we_i) begin
         vpn_mem[idx] <= wdata_i[`TLB_VPN_WIDTH-1:0];
         ro_mem[idx]  <= wdata_i[`TLB_TAG_RO_BIT];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registered read, compared the following cycle

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         rd_valid_q <= 1'b0;
      end else if (rd_en_i) begin
         rd_valid_q <= valid_q[idx];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_vpn_q <= vpn_mem[idx];
         rd_ro_q  <= ro_mem[idx];
      end
   end

   assign hit_o  = rd_valid_q && (rd_vpn_q == req_vpn_i);
   assign prot_o = hit_o && rd_ro_q && req_write_i;   // Write to read-only page

endmodule

`default_nettype wire

//--- rtl/tlb_search_ctrl.sv
// L2 TLB search controller stepping one way per cycle over all banks of a set
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_defines.svh"

module tlb_search_ctrl (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           lookup_valid_i,
   input  logic [`TLB_VA_WIDTH-1:0]       lookup_vaddr_i,
   input  logic                           lookup_write_i,
   output logic                           lookup_ready_o,
   input  logic                           cfg_we_i,
   input  logic [`TLB_CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] cfg_wdata_i,
   input  logic [`TLB_NUM_BANKS-1:0]      bank_hit_i,
   input  logic [`TLB_NUM_BANKS-1:0]      bank_prot_i,
   input  logic                           resp_done_i,
   output logic [`TLB_NUM_BANKS-1:0]      bank_we_o,
   output tlb_l2_pkg::set_idx_t           bank_set_o,
   output tlb_l2_pkg::way_idx_t           bank_way_o,
   output logic [`TLB_CFG_DATA_WIDTH-1:0] bank_wdata_o,
   output logic                           bank_rd_en_o,
   output tlb_l2_pkg::vpn_t               req_vpn_o,
   output logic                           req_write_o,
   output logic                           found_valid_o,
   output tlb_l2_pkg::resp_kind_e         found_kind_o,
   output tlb_l2_pkg::entry_idx_t         found_entry_o,
   output logic [`TLB_PAGE_BITS-1:0]      found_offset_o
);

   localparam tlb_l2_pkg::way_idx_t LAST_WAY = tlb_l2_pkg::way_idx_t'(`TLB_WAYS_PER_BANK - 1);

   tlb_l2_pkg::search_state_e   state_q, state_d;
   tlb_l2_pkg::vpn_t            req_vpn_q;
   tlb_l2_pkg::set_idx_t        set_q;
   logic [`TLB_PAGE_BITS-1:0]   offset_q;
   logic                        req_write_q;
   tlb_l2_pkg::way_idx_t        way_q, way_d_q;
   logic                        issue_end_q, issued_d_q;
   logic                        accept, tag_wr, issue, judge, hit_any;
   logic [`TLB_BANK_BITS-1:0]   hit_bank;

   assign lookup_ready_o = (state_q == tlb_l2_pkg::IDLE);
   assign accept         = lookup_valid_i && lookup_ready_o;
   assign tag_wr         = cfg_we_i && !cfg_addr_i[`TLB_CFG_ADDR_WIDTH-1];
   assign issue = (state_q == tlb_l2_pkg::SEARCH) && !tag_wr && !issue_end_q;   // Paused by writes

   ////////////////////////////////////////////////////////////////////////////
   // Request capture and way counter

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_vpn_q   <= lookup_vaddr_i[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS];
         set_q       <= lookup_vaddr_i[`TLB_PAGE_BITS +: `TLB_SET_BITS];
         offset_q    <= lookup_vaddr_i[`TLB_PAGE_BITS-1:0];
         req_write_q <= lookup_write_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         way_q       <= '0;
         way_d_q     <= '0;
         issue_end_q <= 1'b0;
         issued_d_q  <= 1'b0;
      end else begin
         issued_d_q <= issue;
         way_d_q    <= way_q;   // Way of the read now in the banks
         if (accept) begin
            way_q       <= '0;
            issue_end_q <= 1'b0;
         end else if (issue) begin
            way_q       <= way_q + 1'b1;
            issue_end_q <= (way_q == LAST_WAY);
         end
      end
   end

   // Tag writes take the bank port ahead of the search
   always_comb begin
      for (int b = 0; b < `TLB_NUM_BANKS; b++) begin
         bank_we_o[b] = tag_wr && (cfg_addr_i[`TLB_BANK_BITS-1:0] == `TLB_BANK_BITS'(b));
      end
   end

   assign bank_set_o   = tag_wr ? cfg_addr_i[`TLB_BANK_BITS+`TLB_WAY_BITS +: `TLB_SET_BITS]
                                : set_q;
   assign bank_way_o   = tag_wr ? cfg_addr_i[`TLB_BANK_BITS +: `TLB_WAY_BITS] : way_q;
   assign bank_wdata_o = cfg_wdata_i;
   assign bank_rd_en_o = issue;
   assign req_vpn_o    = req_vpn_q;
   assign req_write_o  = req_write_q;

   ////////////////////////////////////////////////////////////////////////////
   // Result selection, lowest bank wins

   assign judge   = issued_d_q && (state_q == tlb_l2_pkg::SEARCH);
   assign hit_any = |bank_hit_i;

   always_comb begin
      hit_bank = '0;
      for (int b = `TLB_NUM_BANKS - 1; b >= 0; b--) begin
         if (bank_hit_i[b]) hit_bank = `TLB_BANK_BITS'(b);
      end
   end

   always_comb begin
      if (!hit_any)              found_kind_o = tlb_l2_pkg::RESP_MISS;
      else if (bank_prot_i[hit_bank]) found_kind_o = tlb_l2_pkg::RESP_PROT;
      else                       found_kind_o = tlb_l2_pkg::RESP_HIT;
   end

   assign found_valid_o  = judge && (hit_any || (way_d_q == LAST_WAY));
   assign found_entry_o  = {set_q, way_d_q, hit_bank};
   assign found_offset_o = offset_q;

   ////////////////////////////////////////////////////////////////////////////
   // Search FSM

   always_comb begin
      state_d = state_q;
      case (state_q)
         tlb_l2_pkg::IDLE:   if (accept) state_d = tlb_l2_pkg::SEARCH;
         tlb_l2_pkg::SEARCH: if (found_valid_o) state_d = tlb_l2_pkg::DONE;
         tlb_l2_pkg::DONE:   if (resp_done_i) state_d = tlb_l2_pkg::IDLE;
         default:            state_d = tlb_l2_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) state_q <= tlb_l2_pkg::IDLE;
      else         state_q <= state_d;
   end

endmodule

`default_nettype wire

//--- rtl/tlb_pa_lookup.sv
// L2 TLB physical page RAM with response FSM and output handshake
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_defines.svh"

module tlb_pa_lookup (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           cfg_we_i,
   input  logic [`TLB_CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] cfg_wdata_i,
   input  logic                           found_valid_i,
   input  tlb_l2_pkg::resp_kind_e         found_kind_i,
   input  tlb_l2_pkg::entry_idx_t         found_entry_i,
   input  logic [`TLB_PAGE_BITS-1:0]      found_offset_i,
   input  logic                           resp_ready_i,
   output logic                           resp_valid_o,
   output tlb_l2_pkg::resp_kind_e         resp_kind_o,
   output logic [`TLB_PA_WIDTH-1:0]       resp_paddr_o,
   output logic                           resp_done_o
);

   localparam int ENTRY_BITS = $bits(tlb_l2_pkg::entry_idx_t);
   localparam int DEPTH      = `TLB_NUM_SETS * `TLB_WAYS_PER_BANK * `TLB_NUM_BANKS;

   tlb_l2_pkg::resp_state_e     state_q, state_d;
   tlb_l2_pkg::ppn_t            pa_mem [DEPTH];
   tlb_l2_pkg::ppn_t            rd_ppn_q;
   tlb_l2_pkg::entry_idx_t      entry_q, rd_addr;
   logic [`TLB_PAGE_BITS-1:0]   offset_q;
   tlb_l2_pkg::resp_kind_e      kind_q;
   logic [`TLB_PA_WIDTH-1:0]    paddr_q;
   logic                        pa_we, found_hit, take_found, rd_en;

   assign pa_we      = cfg_we_i && cfg_addr_i[`TLB_CFG_ADDR_WIDTH-1];
   assign found_hit  = found_valid_i && (found_kind_i == tlb_l2_pkg::RESP_HIT);
   assign take_found = found_valid_i && (state_q == tlb_l2_pkg::RESP_IDLE);

   ////////////////////////////////////////////////////////////////////////////
   // PA RAM, a config write blocks the read port

   assign rd_en   = !pa_we && ((take_found && found_hit) ||
                               (state_q == tlb_l2_pkg::WAIT_ON_WRITE));
   assign rd_addr = (state_q == tlb_l2_pkg::WAIT_ON_WRITE) ? entry_q : found_entry_i;

   always_ff @(posedge clk_i) begin
      if (pa_we) pa_mem[cfg_addr_i[ENTRY_BITS-1:0]] <= cfg_wdata_i[`TLB_PPN_WIDTH-1:0];
      if (rd_en) rd_ppn_q <= pa_mem[rd_addr];
   end

   always_ff @(posedge clk_i) begin
      if (take_found) begin
         entry_q  <= found_entry_i;   // Kept for the wait state
         offset_q <= found_offset_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response register, held under back-pressure

   always_ff @(posedge clk_i) begin
      if (take_found && !found_hit) begin
         kind_q  <= found_kind_i;
         paddr_q <= '0;   // Miss and fault carry no address
      end else if (state_q == tlb_l2_pkg::READ_PA) begin
         kind_q  <= tlb_l2_pkg::RESP_HIT;
         paddr_q <= {rd_ppn_q, offset_q};
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         tlb_l2_pkg::RESP_IDLE: begin
            if (found_hit) state_d = pa_we ? tlb_l2_pkg::WAIT_ON_WRITE : tlb_l2_pkg::READ_PA;
            else if (found_valid_i) state_d = tlb_l2_pkg::RESP_SEND;
         end
         tlb_l2_pkg::WAIT_ON_WRITE: if (!pa_we) state_d = tlb_l2_pkg::READ_PA;
         tlb_l2_pkg::READ_PA:       state_d = tlb_l2_pkg::RESP_SEND;
         tlb_l2_pkg::RESP_SEND:     if (resp_ready_i) state_d = tlb_l2_pkg::RESP_IDLE;
         default:                   state_d = tlb_l2_pkg::RESP_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) state_q <= tlb_l2_pkg::RESP_IDLE;
      else         state_q <= state_d;
   end

   assign resp_valid_o = (state_q == tlb_l2_pkg::RESP_SEND);
   assign resp_kind_o  = kind_q;
   assign resp_paddr_o = paddr_q;
   assign resp_done_o  = resp_valid_o && resp_ready_i;   // Releases the search FSM

endmodule

`default_nettype wire

//--- rtl/tlb_l2.sv
// L2 TLB top level translating 32-bit virtual to 40-bit physical addresses
`timescale 1ns/1ps
`default_nettype none

`include "tlb_l2_defines.svh"

module tlb_l2 (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   // Lookup request
   input  logic                           lookup_valid_i,
   input  logic [`TLB_VA_WIDTH-1:0]       lookup_vaddr_i,
   input  logic                           lookup_write_i,
   output logic                           lookup_ready_o,
   // Config writes
   input  logic                           cfg_we_i,
   input  logic [`TLB_CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] cfg_wdata_i,
   // Response
   output logic                           resp_valid_o,
   output tlb_l2_pkg::resp_kind_e         resp_kind_o,
   output logic [`TLB_PA_WIDTH-1:0]       resp_paddr_o,
   input  logic                           resp_ready_i
);

   logic [`TLB_NUM_BANKS-1:0]        bank_we, bank_hit, bank_prot;
   tlb_l2_pkg::set_idx_t             bank_set;
   tlb_l2_pkg::way_idx_t             bank_way;
   logic [`TLB_CFG_DATA_WIDTH-1:0]   bank_wdata;
   logic                             bank_rd_en;
   tlb_l2_pkg::vpn_t                 req_vpn;
   logic                             req_write;
   logic                             found_valid;
   tlb_l2_pkg::resp_kind_e           found_kind;
   tlb_l2_pkg::entry_idx_t           found_entry;
   logic [`TLB_PAGE_BITS-1:0]        found_offset;
   logic                             resp_done;

   // Tag banks searched in parallel
   for (genvar b = 0; b < `TLB_NUM_BANKS; b++) begin : g_bank
      tlb_va_bank u_bank (
         .clk_i, .rst_ni,
         .bank_we_i(bank_we[b]), .set_i(bank_set), .way_i(bank_way), .wdata_i(bank_wdata),
         .rd_en_i(bank_rd_en), .req_vpn_i(req_vpn), .req_write_i(req_write),
         .hit_o(bank_hit[b]), .prot_o(bank_prot[b])
      );
   end

   tlb_search_ctrl u_search (
      .clk_i, .rst_ni, .lookup_valid_i, .lookup_vaddr_i, .lookup_write_i, .lookup_ready_o,
      .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
      .bank_hit_i(bank_hit), .bank_prot_i(bank_prot), .resp_done_i(resp_done),
      .bank_we_o(bank_we), .bank_set_o(bank_set), .bank_way_o(bank_way),
      .bank_wdata_o(bank_wdata), .bank_rd_en_o(bank_rd_en),
      .req_vpn_o(req_vpn), .req_write_o(req_write),
      .found_valid_o(found_valid), .found_kind_o(found_kind),
      .found_entry_o(found_entry), .found_offset_o(found_offset)
   );

   tlb_pa_lookup u_pa (
      .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
      .found_valid_i(found_valid), .found_kind_i(found_kind),
      .found_entry_i(found_entry), .found_offset_i(found_offset),
      .resp_ready_i, .resp_valid_o, .resp_kind_o, .resp_paddr_o, .resp_done_o(resp_done)
   );

endmodule

`default_nettype wire

//--- test/tlb_l2_tb.sv
// L2 TLB testbench checking lookups against a table model with back-pressure and config traffic
`timescale 1ns/1ps
`default_nettype none

module tlb_l2_tb;

   localparam int NUM_TESTS   = 5;
   localparam int MAX_LOOKUPS = 32;   // Largest test
   localparam int CYCLE_LIMIT = NUM_TESTS * MAX_LOOKUPS * 40;
   localparam logic [1:0] KIND_HIT  = 2'd0;
   localparam logic [1:0] KIND_MISS = 2'd1;
   localparam logic [1:0] KIND_PROT = 2'd2;

   logic        clk_i;
   logic        rst_ni;
   logic        lookup_valid_i;
   logic [31:0] lookup_vaddr_i;
   logic        lookup_write_i;
   logic        lookup_ready_o;
   logic        cfg_we_i;
   logic [7:0]  cfg_addr_i;
   logic [31:0] cfg_wdata_i;
   logic        resp_valid_o;
   logic [1:0]  resp_kind_o;
   logic [39:0] resp_paddr_o;
   logic        resp_ready_i;

   // Table model, indexed [bank][set][way]
   logic [19:0] m_vpn   [4][8][4];
   logic        m_valid [4][8][4];
   logic        m_ro    [4][8][4];
   logic [27:0] m_ppn   [128];
   logic [19:0] known_vpn [$];

   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;
   string       test_name;
   logic        noise_on = 1'b0;

   tlb_l2 UUT (
      .clk_i, .rst_ni, .lookup_valid_i, .lookup_vaddr_i, .lookup_write_i, .lookup_ready_o,
      .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
      .resp_valid_o, .resp_kind_o, .resp_paddr_o, .resp_ready_i
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("sim failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks and config writes

   task automatic check_val(input string what, input logic [39:0] exp, input logic [39:0] act);
      checks++;
      assert (act === exp)
      else begin
         errors++;
         $display("error %s %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_held(input logic [1:0] kind, input logic [39:0] pa);
      check_val("resp_valid_o held", 40'd1, 40'(resp_valid_o));
      check_val("resp_kind_o held", 40'(kind), 40'(resp_kind_o));
      check_val("resp_paddr_o held", pa, resp_paddr_o);
      check_val("lookup_ready_o while responding", 40'd0, 40'(lookup_ready_o));
   endtask

   // Address is {region, set, way, bank}
   task automatic cfg_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      cfg_we_i    <= 1'b1;
      cfg_addr_i  <= addr;
      cfg_wdata_i <= data;
      if (addr[7]) begin
         m_ppn[addr[6:0]] = data[27:0];
      end else begin
         m_vpn[addr[1:0]][addr[6:4]][addr[3:2]]   = data[19:0];
         m_valid[addr[1:0]][addr[6:4]][addr[3:2]] = data[20];
         m_ro[addr[1:0]][addr[6:4]][addr[3:2]]    = data[21];
      end
   endtask

   task automatic cfg_idle();
      @(posedge clk_i);
      cfg_we_i <= 1'b0;
   endtask

   task automatic program_tag(input logic [1:0] bank, input logic [2:0] set,
                              input logic [1:0] way, input logic [19:0] vpn,
                              input logic valid, input logic ro);
      cfg_write({1'b0, set, way, bank}, {10'd0, ro, valid, vpn});
      if (valid) known_vpn.push_back(vpn);
   endtask

   task automatic program_pa(input logic [6:0] entry, input logic [27:0] ppn);
      cfg_write({1'b1, entry}, {4'd0, ppn});
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Expected result, ways in order and lowest bank first

   task automatic model_lookup(input logic [31:0] va, input logic wr,
                               output logic [1:0] kind, output logic [39:0] pa);
      logic found;
      found = 1'b0;
      kind  = KIND_MISS;
      pa    = '0;
      for (int w = 0; w < 4; w++) begin
         for (int b = 0; b < 4; b++) begin
            if (!found && m_valid[b][va[14:12]][w] && m_vpn[b][va[14:12]][w] == va[31:12]) begin
               found = 1'b1;
               if (m_ro[b][va[14:12]][w] && wr) begin
                  kind = KIND_PROT;
               end else begin
                  kind = KIND_HIT;
                  pa   = {m_ppn[{va[14:12], 2'(w), 2'(b)}], va[11:0]};
               end
            end
         end
      end
   endtask

   function automatic logic [31:0] random_vaddr();
      logic [19:0] vpn;
      if ($urandom_range(0, 3) != 0) vpn = known_vpn[$urandom_range(0, known_vpn.size() - 1)];
      else vpn = 20'($urandom);
      return {vpn, 12'($urandom)};
   endfunction

   // One request through both handshakes
   task automatic do_lookup(input logic [31:0] va, input logic wr, input logic bp);
      logic [1:0]  exp_kind;
      logic [1:0]  got_kind;
      logic [39:0] exp_pa;
      logic [39:0] got_pa;
      int          hold;
      model_lookup(va, wr, exp_kind, exp_pa);
      @(posedge clk_i);
      lookup_valid_i <= 1'b1;
      lookup_vaddr_i <= va;
      lookup_write_i <= wr;
      @(negedge clk_i);
      while (!lookup_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      lookup_valid_i <= 1'b0;
      @(negedge clk_i);
      while (!resp_valid_o) @(negedge clk_i);
      got_kind = resp_kind_o;
      got_pa   = resp_paddr_o;
      check_val("resp_kind_o", 40'(exp_kind), 40'(got_kind));
      check_val("resp_paddr_o", exp_pa, got_pa);
      check_val("lookup_ready_o while responding", 40'd0, 40'(lookup_ready_o));
      if (bp) begin
         hold = $urandom_range(0, 5);
         repeat (hold) begin
            @(negedge clk_i);
            check_held(got_kind, got_pa);
         end
         @(posedge clk_i);
         resp_ready_i <= 1'b1;
         @(negedge clk_i);
         check_held(got_kind, got_pa);
         @(posedge clk_i);
         resp_ready_i <= 1'b0;   // Transfer on this edge
      end else begin
         @(posedge clk_i);
      end
      @(negedge clk_i);
      check_val("resp_valid_o after transfer", 40'd0, 40'(resp_valid_o));
   endtask

   // Random config traffic to every set but the searched one
   task automatic inject_writes(input logic [2:0] busy_set);
      logic [2:0]  set;
      logic [1:0]  way;
      logic [1:0]  bank;
      logic [19:0] vpn;
      while (noise_on) begin
         set  = busy_set + 3'($urandom_range(1, 7));
         way  = 2'($urandom);
         bank = 2'($urandom);
         vpn  = {17'h1F000 + 17'($urandom_range(0, 3)), set};
         case ($urandom_range(0, 3))
            0:       program_tag(bank, set, way, vpn, $urandom_range(0, 3) != 0, 1'($urandom));
            1:       program_pa({set, way, bank}, 28'($urandom));
            default: cfg_idle();
         endcase
      end
      cfg_idle();
   endtask

   task automatic report_test(input int err_start);
      $display("test %-20s %s, %0d errors", test_name,
               (errors == err_start) ? "ok" : "FAILED", errors - err_start);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      int          err_start;
      logic [31:0] va;
      logic        wr;
      void'($urandom(17503));
      rst_ni         = 1'b0;
      lookup_valid_i = 1'b0;
      lookup_vaddr_i = '0;
      lookup_write_i = 1'b0;
      cfg_we_i       = 1'b0;
      cfg_addr_i     = '0;
      cfg_wdata_i    = '0;
      resp_ready_i   = 1'b1;
      for (int b = 0; b < 4; b++)
         for (int s = 0; s < 8; s++)
            for (int w = 0; w < 4; w++)
               m_valid[b][s][w] = 1'b0;
      repeat (5) @(posedge clk_i);
      rst_ni <= 1'b1;

      test_name = "reset";
      err_start = errors;
      @(negedge clk_i);
      check_val("lookup_ready_o after reset", 40'd1, 40'(lookup_ready_o));
      check_val("resp_valid_o after reset", 40'd0, 40'(resp_valid_o));
      do_lookup(32'h1234_5678, 1'b0, 1'b0);
      report_test(err_start);

      // Every PA word gets a value that depends on its full index
      for (int i = 0; i < 128; i++) program_pa(7'(i), 28'h5A0_0000 ^ (28'(i) * 28'h001_0421));
      cfg_idle();

      test_name = "hit";
      err_start = errors;
      for (int i = 0; i < 8; i++) begin
         program_tag(2'(i % 4), 3'(i), 2'((i * 3) % 4), {17'(i * 1111 + 171), 3'(i)}, 1'b1, 1'b0);
      end
      program_tag(2'd2, 3'd0, 2'd0, known_vpn[0], 1'b1, 1'b0);   // Lower bank 0 must win
      program_tag(2'd3, 3'd2, 2'd3, 20'hCAFE2, 1'b0, 1'b0);       // Invalid entry
      program_pa(7'h37, 28'hABC_DEF0);
      cfg_idle();
      for (int i = 0; i < 8; i++) do_lookup({known_vpn[i], 12'($urandom)}, 1'b0, 1'b0);
      do_lookup({20'hCAFE2, 12'h444}, 1'b0, 1'b0);
      report_test(err_start);

      test_name = "protection";
      err_start = errors;
      program_tag(2'd1, 3'd6, 2'd2, {17'h0F00D, 3'd6}, 1'b1, 1'b1);
      cfg_idle();
      do_lookup({17'h0F00D, 3'd6, 12'h3A5}, 1'b1, 1'b0);
      do_lookup({17'h0F00D, 3'd6, 12'h3A5}, 1'b0, 1'b0);
      do_lookup({known_vpn[0], 12'h010}, 1'b1, 1'b0);
      report_test(err_start);

      test_name = "back_pressure";
      err_start = errors;
      @(posedge clk_i);
      resp_ready_i <= 1'b0;
      for (int i = 0; i < 16; i++) do_lookup(random_vaddr(), 1'($urandom), 1'b1);
      @(posedge clk_i);
      resp_ready_i <= 1'b1;
      report_test(err_start);

      test_name = "write_during_search";
      err_start = errors;
      for (int i = 0; i < MAX_LOOKUPS; i++) begin
         va       = random_vaddr();
         wr       = 1'($urandom);
         noise_on = 1'b1;
         fork
            begin
               do_lookup(va, wr, 1'b0);
               noise_on = 1'b0;
            end
            inject_writes(va[14:12]);
         join
      end
      report_test(err_start);

      $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
rtl/tlb_l2_pkg.sv
rtl/tlb_va_bank.sv
rtl/tlb_search_ctrl.sv
rtl/tlb_pa_lookup.sv
rtl/tlb_l2.sv
test/tlb_l2_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the L2 TLB testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tlb_l2_tb -o tlb_l2_sim
./obj_dir/tlb_l2_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
   echo "run_sim: simulation reported success"
else
   echo "run_sim: simulation reported failure" >&2
   exit 1
fi
